/* logic/integer_defines.svh */
`ifndef INTEGER_DEFINES_SVH
`define INTEGER_DEFINES_SVH

// Architectural register count, 16 selects RV32E
`define REGISTER_COUNT 32

// Width of one register and of the ALU datapath
`define DATA_WIDTH 32

// Major opcode field values, instruction[6:0]
`define OPCODE_OP     7'b0110011 // Register-register ALU group
`define OPCODE_OP_IMM 7'b0010011 // Register-immediate ALU group
`define OPCODE_LUI    7'b0110111

// Funct7 values that select the alternate operation
`define FUNCT7_BASE      7'b0000000
`define FUNCT7_ALTERNATE 7'b0100000

`endif

/* logic/integerTypes.sv */
`include "integer_defines.svh"

package integerTypes;

	// Major opcodes handled by this slice
	typedef enum logic [6:0]
	{
		op    = `OPCODE_OP,
		opImm = `OPCODE_OP_IMM,
		lui   = `OPCODE_LUI
	} Opcode_t;

	typedef enum logic [3:0]
	{
		add,
		sub,
		sll,
		slt,
		sltu,
		xorOp,
		srl,
		sra,
		orOp,
		andOp,
		passB // LUI, operand B straight through
	} AluOp_t;

	// Register addresses pulled out of the instruction
	typedef struct packed
	{
		logic [4:0] rs1Address;
		logic [4:0] rs2Address;
		logic [4:0] rdAddress;
	} DecodedAddresses_t;

	typedef struct packed
	{
		DecodedAddresses_t addresses;
		AluOp_t aluOp;
		logic [`DATA_WIDTH-1:0] immediate; // Already extended, or shifted up for LUI
		logic useImmediate;
		logic writeEnable; // Gated by valid, legality and rd != x0
	} DecodedInstruction_t;

endpackage

/* logic/InstructionDecoder.sv */
`timescale 1ns/100ps
`include "integer_defines.svh"

module InstructionDecoder
#(
	parameter numberOfRegisters = 32
)
(
	input logic [31:0] instruction,
	input logic instructionValid,
	output integerTypes::DecodedInstruction_t decoded,
	output logic illegalInstruction
);

logic [6:0] opcodeField;
logic [2:0] funct3;
logic [6:0] funct7;
integerTypes::Opcode_t opcode;
integerTypes::DecodedAddresses_t addresses;
integerTypes::AluOp_t aluOp;
logic [31:0] immediate;
logic useImmediate;
logic legalOpcode, legalFunct, highAddressUsed, legal;

assign opcodeField = instruction[6:0];
assign funct3 = instruction[14:12];
assign funct7 = instruction[31:25];
assign opcode = integerTypes::Opcode_t'(opcodeField);

assign addresses = '{
	rs1Address: instruction[19:15],
	rs2Address: instruction[24:20],
	rdAddress: instruction[11:7]
};

// U-type for LUI, I-type sign extended otherwise
assign immediate = (opcode == integerTypes::lui) ? {instruction[31:12], 12'h000}
	: {{20{instruction[31]}}, instruction[31:20]};
assign useImmediate = (opcode != integerTypes::op);

always_comb
begin
	legalFunct = 1'b1;
	unique case (funct3)
		3'b000: aluOp = (opcode == integerTypes::op && instruction[30]) ? integerTypes::sub
			: integerTypes::add; // ADDI has no SUB form
		3'b001: aluOp = integerTypes::sll;
		3'b010: aluOp = integerTypes::slt;
		3'b011: aluOp = integerTypes::sltu;
		3'b100: aluOp = integerTypes::xorOp;
		3'b101: aluOp = instruction[30] ? integerTypes::sra : integerTypes::srl;
		3'b110: aluOp = integerTypes::orOp;
		3'b111: aluOp = integerTypes::andOp;
	endcase

	case (opcode)
		integerTypes::op:
			legalFunct = (funct7 == `FUNCT7_BASE) || ((funct7 == `FUNCT7_ALTERNATE)
				&& (funct3 == 3'b000 || funct3 == 3'b101));
		integerTypes::opImm:
		begin
			if (funct3 == 3'b001) // SLLI
				legalFunct = (funct7 == `FUNCT7_BASE);
			else if (funct3 == 3'b101) // SRLI or SRAI
				legalFunct = (funct7 == `FUNCT7_BASE) || (funct7 == `FUNCT7_ALTERNATE);
		end
		integerTypes::lui: aluOp = integerTypes::passB;
		default: aluOp = integerTypes::add; // Unknown opcode, caught below
	endcase
end

assign legalOpcode = opcodeField inside {`OPCODE_OP, `OPCODE_OP_IMM, `OPCODE_LUI};

// Only fields the instruction actually reads count against RV32E
assign highAddressUsed = addresses.rdAddress[4]
	|| (opcode != integerTypes::lui && addresses.rs1Address[4])
	|| (opcode == integerTypes::op && addresses.rs2Address[4]);

assign legal = legalOpcode && legalFunct && !(numberOfRegisters == 16 && highAddressUsed);
assign illegalInstruction = instructionValid && !legal;

assign decoded = '{
	addresses: addresses,
	aluOp: aluOp,
	immediate: immediate,
	useImmediate: useImmediate,
	writeEnable: instructionValid && legal && (addresses.rdAddress != 5'd0)
};

endmodule

/* logic/RegisterFile.sv */
`timescale 1ns/100ps
`include "integer_defines.svh"

module RegisterFile
#(
	parameter numberOfRegisters = 32
)
(
	input logic clock, reset,
	input integerTypes::DecodedAddresses_t decodedAddresses,
	output logic [`DATA_WIDTH-1:0] rs1, rs2,
	output logic [`DATA_WIDTH-1:0] highRegister,
	input logic [`DATA_WIDTH-1:0] rd,
	input logic rdWriteEnable
);

logic [`DATA_WIDTH-1:0] registers [numberOfRegisters-1:1]; // No storage behind x0
logic [`DATA_WIDTH-1:0] readView [31:1];

// Addresses past the implemented file read as zero
for (genvar i = 1; i < 32; i++)
begin : viewEntry
	if (i < numberOfRegisters)
		assign readView[i] = registers[i];
	else
		assign readView[i] = '0;
end

// Every entry spelled out so the port stays a single flat mux
function automatic logic [`DATA_WIDTH-1:0] readRegister(input logic [4:0] address);
	unique case (address)
		5'd0: readRegister = '0; // x0 hard zero
		5'd1: readRegister = readView[1];
		5'd2: readRegister = readView[2];
		5'd3: readRegister = readView[3];
		5'd4: readRegister = readView[4];
		5'd5: readRegister = readView[5];
		5'd6: readRegister = readView[6];
		5'd7: readRegister = readView[7];
		5'd8: readRegister = readView[8];
		5'd9: readRegister = readView[9];
		5'd10: readRegister = readView[10];
		5'd11: readRegister = readView[11];
		5'd12: readRegister = readView[12];
		5'd13: readRegister = readView[13];
		5'd14: readRegister = readView[14];
		5'd15: readRegister = readView[15];
		5'd16: readRegister = readView[16];
		5'd17: readRegister = readView[17];
		5'd18: readRegister = readView[18];
		5'd19: readRegister = readView[19];
		5'd20: readRegister = readView[20];
		5'd21: readRegister = readView[21];
		5'd22: readRegister = readView[22];
		5'd23: readRegister = readView[23];
		5'd24: readRegister = readView[24];
		5'd25: readRegister = readView[25];
		5'd26: readRegister = readView[26];
		5'd27: readRegister = readView[27];
		5'd28: readRegister = readView[28];
		5'd29: readRegister = readView[29];
		5'd30: readRegister = readView[30];
		5'd31: readRegister = readView[31];
	endcase
endfunction

assign rs1 = readRegister(decodedAddresses.rs1Address);
assign rs2 = readRegister(decodedAddresses.rs2Address);
assign highRegister = registers[numberOfRegisters-1]; // x31, or x15 for RV32E

always_ff @(posedge clock, posedge reset)
begin
	if (reset)
	begin
		for (int i = 1; i < numberOfRegisters; i++)
			registers[i] <= '0;
	end
	else if (rdWriteEnable) // Decoder already excludes x0 and out-of-range rd
		registers[decodedAddresses.rdAddress] <= rd;
end

endmodule

/* logic/IntegerAlu.sv */
`timescale 1ns/100ps
`include "integer_defines.svh"

module IntegerAlu
(
	input integerTypes::AluOp_t aluOp,
	input logic [`DATA_WIDTH-1:0] rs1, rs2,
	input logic [`DATA_WIDTH-1:0] immediate,
	input logic useImmediate,
	output logic [`DATA_WIDTH-1:0] result
);

logic [`DATA_WIDTH-1:0] operandB;
logic [4:0] shiftAmount;
logic signedLess, unsignedLess;

assign operandB = useImmediate ? immediate : rs2;
assign shiftAmount = operandB[4:0]; // Shamt field for the immediate forms

assign signedLess = $signed(rs1) < $signed(operandB);
assign unsignedLess = rs1 < operandB;

always_comb
begin
	case (aluOp)
		integerTypes::add:
			result = rs1 + operandB;
		integerTypes::sub:
			result = rs1 - operandB;
		integerTypes::sll:
			result = rs1 << shiftAmount;
		integerTypes::slt:
			result = {{(`DATA_WIDTH-1){1'b0}}, signedLess};
		integerTypes::sltu:
			result = {{(`DATA_WIDTH-1){1'b0}}, unsignedLess};
		integerTypes::xorOp:
			result = rs1 ^ operandB;
		integerTypes::srl:
			result = rs1 >> shiftAmount;
		integerTypes::sra:
			result = $signed(rs1) >>> shiftAmount; // Sign bit fills from the left
		integerTypes::orOp:
			result = rs1 | operandB;
		integerTypes::andOp:
			result = rs1 & operandB;
		integerTypes::passB:
			result = operandB;
		default:
			result = '0; // Encodings past passB are never decoded
	endcase
end

endmodule

/* logic/IntegerExecute.sv */
`timescale 1ns/100ps
`include "integer_defines.svh"

module IntegerExecute
#(
	parameter numberOfRegisters = `REGISTER_COUNT
)
(
	input logic clock, reset,
	input logic [31:0] instruction,
	input logic instructionValid,
	output logic [31:0] result,
	output logic illegalInstruction,
	output logic [31:0] highRegister
);

integerTypes::DecodedInstruction_t decoded;
logic [31:0] rs1, rs2;

InstructionDecoder #(.numberOfRegisters(numberOfRegisters)) decoder
(
	.instruction(instruction),
	.instructionValid(instructionValid),
	.decoded(decoded),
	.illegalInstruction(illegalInstruction)
);

RegisterFile #(.numberOfRegisters(numberOfRegisters)) registerFile
(
	.clock(clock),
	.reset(reset),
	.decodedAddresses(decoded.addresses),
	.rs1(rs1),
	.rs2(rs2),
	.highRegister(highRegister),
	.rd(result), // ALU result written back at the next edge
	.rdWriteEnable(decoded.writeEnable)
);

IntegerAlu alu
(
	.aluOp(decoded.aluOp),
	.rs1(rs1),
	.rs2(rs2),
	.immediate(decoded.immediate),
	.useImmediate(decoded.useImmediate),
	.result(result)
);

endmodule

/* tests/RegisterFile_chk.sv */
`timescale 1ns/100ps
`include "integer_defines.svh"

module RegisterFile_chk
#(
	parameter numberOfRegisters = 32
)
(
	input logic clock, reset,
	input integerTypes::DecodedAddresses_t decodedAddresses,
	input logic [`DATA_WIDTH-1:0] rs1, highRegister, rd,
	input logic rdWriteEnable,
	input logic [`DATA_WIDTH-1:0] registers [numberOfRegisters-1:1]
);

int failureCount = 0;
logic lastWrite;
logic [4:0] lastAddress;
logic [`DATA_WIDTH-1:0] lastData;

// Previous cycle's write, compared against the array one edge later
always_ff @(posedge clock, posedge reset)
begin
	if (reset)
	begin
		lastWrite <= 1'b0;
		lastAddress <= '0;
		lastData <= '0;
	end
	else
	begin
		lastWrite <= rdWriteEnable;
		lastAddress <= decodedAddresses.rdAddress;
		lastData <= rd;
	end
end

rs1ZeroForX0: assert property (@(posedge clock) disable iff (reset)
	(decodedAddresses.rs1Address == 5'd0) |-> (rs1 == '0))
else
begin
	$error("rs1 is nonzero while reading x0");
	failureCount++;
end

highRegisterClearAfterReset: assert property (@(posedge clock)
	$fell(reset) |-> (highRegister == '0))
else
begin
	$error("highRegister is not zero after reset");
	failureCount++;
end

writeCommits: assert property (@(posedge clock) disable iff (reset)
	lastWrite |-> (registers[lastAddress] == lastData))
else
begin
	$error("written register does not hold the written data");
	failureCount++;
end

endmodule

bind RegisterFile RegisterFile_chk #(.numberOfRegisters(numberOfRegisters)) registerFileChecks
(
	.clock(clock),
	.reset(reset),
	.decodedAddresses(decodedAddresses),
	.rs1(rs1),
	.highRegister(highRegister),
	.rd(rd),
	.rdWriteEnable(rdWriteEnable),
	.registers(registers)
);

/* tests/IntegerExecuteTb.sv */
`timescale 1ns/100ps
`include "integer_defines.svh"

module IntegerExecuteTb;

typedef struct packed
{
	logic [31:0] instruction;
	logic valid;
} StimulusEntry_t;

localparam logic [4:0] highAddress = 5'(`REGISTER_COUNT - 1); // x31, or x15 for RV32E

logic clock = 1'b0;
logic reset;
logic [31:0] instruction;
logic instructionValid;
logic [31:0] result;
logic illegalInstruction;
logic [31:0] highRegister;

StimulusEntry_t stimulus [$];
logic [31:0] modelRegisters [0:31];
logic [31:0] lcgState;
logic tableBuilt = 1'b0;

IntegerExecute u_dut
(
	.clock(clock),
	.reset(reset),
	.instruction(instruction),
	.instructionValid(instructionValid),
	.result(result),
	.illegalInstruction(illegalInstruction),
	.highRegister(highRegister)
);

always #4 clock = ~clock;

function logic [31:0] nextRandom();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return lcgState;
endfunction

// Top bit forced so the sign extension is exercised
function automatic logic [11:0] negativeImmediate();
	logic [31:0] value;
	value = nextRandom();
	return {1'b1, value[26:16]};
endfunction

function automatic logic [31:0] rType(input logic [6:0] funct7, input logic [4:0] rs2, rs1,
	input logic [2:0] funct3, input logic [4:0] rd);
	return {funct7, rs2, rs1, funct3, rd, `OPCODE_OP};
endfunction

function automatic logic [31:0] iType(input logic [11:0] immediate, input logic [4:0] rs1,
	input logic [2:0] funct3, input logic [4:0] rd);
	return {immediate, rs1, funct3, rd, `OPCODE_OP_IMM};
endfunction

function automatic logic [31:0] uType(input logic [19:0] upper, input logic [4:0] rd);
	return {upper, rd, `OPCODE_LUI};
endfunction

function automatic logic [31:0] readModel(input logic [4:0] address);
	return (address == 5'd0) ? 32'd0 : modelRegisters[address];
endfunction

function automatic logic modelIllegal(input logic [31:0] word);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic bad;
	opcode = word[6:0];
	funct3 = word[14:12];
	funct7 = word[31:25];
	if (opcode == `OPCODE_OP)
		bad = !(funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)));
	else if (opcode == `OPCODE_OP_IMM)
		bad = (funct3 == 3'd1 && funct7 != 7'h00)
			|| (funct3 == 3'd5 && funct7 != 7'h00 && funct7 != 7'h20);
	else
		bad = (opcode != `OPCODE_LUI);
	if (`REGISTER_COUNT == 16)
		bad = bad || word[11] || (opcode != `OPCODE_LUI && word[19])
			|| (opcode == `OPCODE_OP && word[24]);
	return bad;
endfunction

// Expected ALU value from the ISA rules and the pre-edge model state
function automatic logic [31:0] modelResult(input logic [31:0] word);
	logic [31:0] a, b, value;
	logic [4:0] amount;
	a = readModel(word[19:15]);
	b = (word[6:0] == `OPCODE_OP) ? readModel(word[24:20]) : {{20{word[31]}}, word[31:20]};
	amount = b[4:0];
	case (word[14:12])
		3'd0: value = (word[6:0] == `OPCODE_OP && word[30]) ? a - b : a + b;
		3'd1: value = a << amount;
		3'd2: value = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
		3'd3: value = {31'd0, a < b};
		3'd4: value = a ^ b;
		3'd5: value = (word[30] && a[31]) ? ~(~a >> amount) : a >> amount;
		3'd6: value = a | b;
		default: value = a & b;
	endcase
	if (word[6:0] == `OPCODE_LUI)
		value = {word[31:12], 12'h000};
	return value;
endfunction

task automatic checkValue(input logic [31:0] actual, expected, input string what);
	if (actual !== expected)
	begin
		$display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
		$display("** FAIL **");
		$fatal(1, "stopping at the first mismatch");
	end
endtask

task automatic addEntry(input logic [31:0] word, input logic valid);
	stimulus.push_back('{instruction: word, valid: valid});
endtask

task automatic buildTable();
	lcgState = 32'd34;
	addEntry(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b1); // ADD right after reset
	addEntry(iType(negativeImmediate(), 5'd0, 3'd0, 5'd1), 1'b1); // ADDI
	addEntry(iType(negativeImmediate(), 5'd1, 3'd4, 5'd2), 1'b1); // XORI
	addEntry(iType(negativeImmediate(), 5'd1, 3'd6, 5'd3), 1'b1); // ORI
	addEntry(iType(negativeImmediate(), 5'd2, 3'd7, 5'd4), 1'b1); // ANDI
	addEntry(iType(negativeImmediate(), 5'd1, 3'd2, 5'd5), 1'b1); // SLTI
	addEntry(iType(negativeImmediate(), 5'd1, 3'd3, 5'd6), 1'b1); // SLTIU
	addEntry(iType(12'd5, 5'd0, 3'd0, 5'd7), 1'b1);
	addEntry(iType(12'd100, 5'd0, 3'd0, 5'd8), 1'b1);
	addEntry(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd9), 1'b1); // ADD
	addEntry(rType(7'h20, 5'd8, 5'd1, 3'd0, 5'd10), 1'b1); // SUB
	addEntry(rType(7'h00, 5'd7, 5'd1, 3'd1, 5'd11), 1'b1); // SLL
	addEntry(rType(7'h00, 5'd8, 5'd1, 3'd2, 5'd12), 1'b1); // SLT with negative x1
	addEntry(rType(7'h00, 5'd8, 5'd1, 3'd3, 5'd13), 1'b1); // SLTU
	addEntry(rType(7'h00, 5'd2, 5'd1, 3'd4, 5'd14), 1'b1); // XOR
	addEntry(rType(7'h00, 5'd7, 5'd1, 3'd5, 5'd15), 1'b1); // SRL
	addEntry(rType(7'h20, 5'd7, 5'd1, 3'd5, 5'd9), 1'b1); // SRA
	addEntry(rType(7'h00, 5'd4, 5'd2, 3'd6, 5'd10), 1'b1); // OR
	addEntry(rType(7'h00, 5'd3, 5'd2, 3'd7, 5'd11), 1'b1); // AND
	addEntry(iType({7'h00, 5'd3}, 5'd1, 3'd1, 5'd12), 1'b1); // SLLI
	addEntry(iType({7'h20, 5'd4}, 5'd1, 3'd5, 5'd13), 1'b1); // SRAI
	addEntry(iType({7'h00, 5'd4}, 5'd1, 3'd5, 5'd14), 1'b1); // SRLI
	addEntry(iType(12'd7, 5'd1, 3'd0, 5'd0), 1'b1); // Write to x0 is dropped
	addEntry(rType(7'h00, 5'd1, 5'd0, 3'd0, 5'd14), 1'b1);
	addEntry(uType(20'h12345, 5'd5), 1'b1);
	addEntry(iType(12'h678, 5'd5, 3'd0, 5'd5), 1'b1);
	addEntry(uType(20'hDEADC, 5'd6), 1'b1);
	addEntry(iType(12'hEEF, 5'd6, 3'd0, 5'd6), 1'b1); // Negative low part borrows
	addEntry({12'h001, 5'd1, 3'd0, 5'd3, 7'b1111011}, 1'b1); // Unknown opcode
	addEntry(rType(7'h01, 5'd2, 5'd1, 3'd0, 5'd4), 1'b1); // MUL is not supported
	addEntry(iType({7'h20, 5'd1}, 5'd1, 3'd1, 5'd5), 1'b1); // SLLI with bad funct7
	addEntry(rType(7'h20, 5'd2, 5'd1, 3'd4, 5'd6), 1'b1);
	addEntry(rType(7'h00, 5'd4, 5'd3, 3'd0, 5'd7), 1'b1); // x3 and x4 untouched
	addEntry(rType(7'h00, 5'd6, 5'd5, 3'd0, 5'd8), 1'b1);
	addEntry(iType(12'd99, 5'd0, 3'd0, 5'd8), 1'b0); // Not valid so nothing is written
	addEntry({12'h001, 5'd1, 3'd0, 5'd8, 7'b1111011}, 1'b0); // Illegal flag held low
	addEntry(rType(7'h00, 5'd0, 5'd8, 3'd0, 5'd9), 1'b1);
	addEntry(iType(negativeImmediate(), 5'd1, 3'd0, highAddress), 1'b1);
	addEntry(rType(7'h00, 5'd0, highAddress, 3'd0, 5'd1), 1'b1);
endtask

// Watchdog sized from the table
initial
begin
	wait (tableBuilt);
	#((stimulus.size() + 10) * 8);
	$display("Timeout: the stimulus table did not finish in the expected time");
	$display("** FAIL **");
	$fatal(1, "watchdog expired");
end

initial
begin
	StimulusEntry_t entry;
	logic [31:0] expectedResult;
	logic expectedIllegal;
	reset = 1'b1;
	instruction = '0;
	instructionValid = 1'b0;
	for (int r = 0; r < 32; r++)
		modelRegisters[r] = '0;
	buildTable();
	tableBuilt = 1'b1;
	repeat (4) @(posedge clock);
	#1;
	reset = 1'b0;
	checkValue(highRegister, 32'd0, "highRegister after reset");
	for (int i = 0; i < stimulus.size(); i++)
	begin
		entry = stimulus[i];
		instruction = entry.instruction;
		instructionValid = entry.valid;
		expectedIllegal = entry.valid && modelIllegal(entry.instruction);
		expectedResult = modelResult(entry.instruction);
		#5; // Combinational outputs settled well before the edge
		checkValue(illegalInstruction, expectedIllegal,
			$sformatf("entry %0d illegal flag", i));
		if (entry.valid && !expectedIllegal)
			checkValue(result, expectedResult, $sformatf("entry %0d result", i));
		@(posedge clock);
		if (entry.valid && !expectedIllegal && entry.instruction[11:7] != 5'd0)
			modelRegisters[entry.instruction[11:7]] = expectedResult;
		#1;
		checkValue(highRegister, modelRegisters[highAddress],
			$sformatf("entry %0d highRegister", i));
	end
	instructionValid = 1'b0;
	repeat (2) @(posedge clock);
	#1;
	if (u_dut.registerFile.registerFileChecks.failureCount != 0)
	begin
		$display("The register file checker saw assertion failures");
		$display("** FAIL **");
		$fatal(1, "assertion failures");
	end
	else
	begin
		$display("** PASS **");
		$finish;
	end
end

endmodule

/* integerExecute.f */
+incdir+logic
logic/integerTypes.sv
logic/InstructionDecoder.sv
logic/RegisterFile.sv
logic/IntegerAlu.sv
logic/IntegerExecute.sv
tests/RegisterFile_chk.sv
tests/IntegerExecuteTb.sv

/* Bender.yml */
package:
  name: integerExecute

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/integerTypes.sv
      - logic/InstructionDecoder.sv
      - logic/RegisterFile.sv
      - logic/IntegerAlu.sv
      - logic/IntegerExecute.sv

  - target: test
    include_dirs:
      - logic
    files:
      - tests/RegisterFile_chk.sv
      - tests/IntegerExecuteTb.sv
